// ==== sources.f ====
smpc_pkg.sv
smpc_host_decode.sv
smpc_cmd_exec.sv
smpc_status_result.sv
smpc_top.sv
tb_smpc.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f sources.f --top-module tb_smpc -o sim_smpc
out=$(./obj_dir/sim_smpc)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Test passed"; then
	exit 0
fi
exit 1

// ==== tb_smpc.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_smpc;

	localparam int NUM_ROWS   = 15;
	localparam int MAX_CYCLES = NUM_ROWS * 1200 + 200;

	// Host A values for byte address {A,1}
	localparam logic [5:0] A_IREG0  = 6'h00;
	localparam logic [5:0] A_IREG1  = 6'h01;
	localparam logic [5:0] A_IREG2  = 6'h02;
	localparam logic [5:0] A_COMREG = 6'h0F;
	localparam logic [5:0] A_OREG0  = 6'h10;
	localparam logic [5:0] A_SR     = 6'h30;
	localparam logic [5:0] A_SF     = 6'h31;

	// lines = {MSHRES_N, MSHNMI_N, SSHRES_N, SNDRES_N, CDRES_N} after the command
	typedef struct packed {
		logic [7:0] cmd;
		logic [7:0] ireg0;
		logic [7:0] ireg2;
		logic [4:0] lines;
	} row_t;

	logic       CLK;
	logic       RST_N;
	logic       CE;
	logic [3:0] AC;
	logic [5:0] A;
	logic [7:0] DI;
	logic       CS_N;
	logic       RW_N;
	wire  [7:0] DO;
	wire        MSHRES_N;
	wire        MSHNMI_N;
	wire        SSHRES_N;
	wire        SSHNMI_N;
	wire        SNDRES_N;
	wire        CDRES_N;
	wire        MIRQ_N;

	row_t        test_table [NUM_ROWS];
	row_t        row;
	integer      seed = 32'h1fb5_eee2;
	logic [31:0] rnd;
	logic [3:0]  nib;
	logic [7:0]  data;
	logic [7:0]  exp_byte;
	logic [7:0]  exp_oreg31;
	logic [2:0]  exp_sr_hi;
	logic        exp_resd;
	logic        intback_ok;
	int          errors = 0;
	int          cycle_cnt = 0;
	int          nmi_low_cycles = 0;
	int          mirq_low_cycles = 0;
	int          nmi_before;
	int          mirq_before;

	smpc_pkg::exec_state_t exec_st;	// Waveform view only
	assign exec_st = u_dut.u_exec.st;

	smpc_top #(
		.CMD_DELAY (8)
	) u_dut (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.CE       (CE),
		.AC       (AC),
		.A        (A),
		.DI       (DI),
		.CS_N     (CS_N),
		.RW_N     (RW_N),
		.DO       (DO),
		.MSHRES_N (MSHRES_N),
		.MSHNMI_N (MSHNMI_N),
		.SSHRES_N (SSHRES_N),
		.SSHNMI_N (SSHNMI_N),
		.SNDRES_N (SNDRES_N),
		.CDRES_N  (CDRES_N),
		.MIRQ_N   (MIRQ_N)
	);

	always #20 CLK = ~CLK;

	// Count low cycles of the pulsed lines
	always @(negedge CLK) begin
		if (!MSHNMI_N)
			nmi_low_cycles <= nmi_low_cycles + 1;
		if (!MIRQ_N)
			mirq_low_cycles <= mirq_low_cycles + 1;
	end

	always @(posedge CLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, a command never completed", cycle_cnt);
			$display("Test failed");
			$finish;
		end
	end

	task automatic write_reg(input logic [5:0] adr, input logic [7:0] wdata);
		@(posedge CLK);
		#2;
		A = adr;
		DI = wdata;
		CS_N = 1'b0;
		RW_N = 1'b1;
		@(posedge CLK);
		#2;
		RW_N = 1'b0;	// Falling RW_N takes the write
		@(posedge CLK);
		#2;
		RW_N = 1'b1;
		CS_N = 1'b1;
	endtask

	task automatic read_reg(input logic [5:0] adr, output logic [7:0] rdata);
		@(posedge CLK);
		#2;
		A = adr;
		RW_N = 1'b1;
		CS_N = 1'b0;
		@(posedge CLK);
		@(posedge CLK);
		#2;
		rdata = DO;	// Registered two edges after the CS_N fall
		CS_N = 1'b1;
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			errors = errors + 1;
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors = errors + 1;
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_lines(input logic [4:0] lines);
		check_bit("MSHRES_N", MSHRES_N, lines[4]);
		check_bit("MSHNMI_N", MSHNMI_N, lines[3]);
		check_bit("SSHRES_N", SSHRES_N, lines[2]);
		check_bit("SNDRES_N", SNDRES_N, lines[1]);
		check_bit("CDRES_N", CDRES_N, lines[0]);
		check_bit("SSHNMI_N", SSHNMI_N, 1'b1);
		check_bit("MIRQ_N", MIRQ_N, 1'b1);
	endtask

	initial begin
		CLK = 1'b0;
		RST_N = 1'b0;
		CE = 1'b1;
		AC = 4'h0;
		A = '0;
		DI = '0;
		CS_N = 1'b1;
		RW_N = 1'b1;

		test_table[0]  = {smpc_pkg::CMD_MSHON,   8'h00, 8'h00, 5'b11001};
		test_table[1]  = {smpc_pkg::CMD_SSHON,   8'h00, 8'h00, 5'b11101};
		test_table[2]  = {smpc_pkg::CMD_INTBACK, 8'h00, 8'hF0, 5'b11101};	// Bit 0 clear
		test_table[3]  = {smpc_pkg::CMD_INTBACK, 8'h01, 8'h55, 5'b11101};	// Wrong key
		test_table[4]  = {smpc_pkg::CMD_SNDON,   8'h00, 8'h00, 5'b11111};
		test_table[5]  = {smpc_pkg::CMD_CDOFF,   8'h00, 8'h00, 5'b11110};
		test_table[6]  = {smpc_pkg::CMD_NMIREQ,  8'h00, 8'h00, 5'b11110};
		test_table[7]  = {smpc_pkg::CMD_RESENAB, 8'h00, 8'h00, 5'b11110};
		test_table[8]  = {smpc_pkg::CMD_INTBACK, 8'h01, 8'hF0, 5'b11110};
		test_table[9]  = {smpc_pkg::CMD_SSHOFF,  8'h00, 8'h00, 5'b11010};
		test_table[10] = {smpc_pkg::CMD_SNDOFF,  8'h00, 8'h00, 5'b11000};
		test_table[11] = {smpc_pkg::CMD_CDON,    8'h00, 8'h00, 5'b11001};
		test_table[12] = {smpc_pkg::CMD_RESDISA, 8'h00, 8'h00, 5'b11001};
		test_table[13] = {smpc_pkg::CMD_INTBACK, 8'h01, 8'hF0, 5'b11001};
		test_table[14] = {8'h05,                 8'h00, 8'h00, 5'b11001};	// Unknown code

		exp_resd = 1'b1;
		exp_sr_hi = 3'b000;
		exp_oreg31 = 8'h00;

		repeat (5) @(posedge CLK);
		#2;
		RST_N = 1'b1;

		check_lines(5'b11001);
		read_reg(A_SF, data);
		check_byte("SF", data, 8'hF0);
		read_reg(A_SR, data);
		check_byte("SR", data, 8'h00);

		for (int i = 0; i < NUM_ROWS; i++) begin
			row = test_table[i];
			rnd = $random(seed);
			AC = rnd[3:0];
			nib = rnd[7:4];
			write_reg(A_IREG0, row.ireg0);
			write_reg(A_IREG1, {nib, 4'h0});
			write_reg(A_IREG2, row.ireg2);
			write_reg(A_SF, 8'h01);

			intback_ok = (row.cmd == smpc_pkg::CMD_INTBACK) && (row.ireg2 == 8'hF0)
				&& row.ireg0[0];
			if (row.cmd == smpc_pkg::CMD_RESENAB)
				exp_resd = 1'b0;
			if (row.cmd == smpc_pkg::CMD_RESDISA)
				exp_resd = 1'b1;
			if (row.cmd != smpc_pkg::CMD_INTBACK || intback_ok)
				exp_oreg31 = row.cmd;	// Rejected INTBACK skips the echo
			if (intback_ok)
				exp_sr_hi = 3'b010;

			nmi_before = nmi_low_cycles;
			mirq_before = mirq_low_cycles;
			write_reg(A_COMREG, row.cmd);
			do begin
				read_reg(A_SF, data);
			end while (data[0]);
			check_byte("SF", data, 8'hF0);

			check_lines(row.lines);
			if ((row.cmd == smpc_pkg::CMD_NMIREQ) != (nmi_low_cycles > nmi_before)) begin
				errors = errors + 1;
				$display("Row %0d: MSHNMI_N pulse was wrong for command 0x%h", i, row.cmd);
			end
			if (intback_ok != (mirq_low_cycles > mirq_before)) begin
				errors = errors + 1;
				$display("Row %0d: MIRQ_N pulse was wrong for command 0x%h", i, row.cmd);
			end

			read_reg(A_OREG0 + 6'd31, data);
			check_byte("OREG31", data, exp_oreg31);
			read_reg(A_SR, data);
			check_byte("SR", data, {exp_sr_hi, 1'b0, nib});

			if (intback_ok) begin
				for (int n = 0; n < 16; n++) begin
					case (n)
						0:       exp_byte = {1'b0, exp_resd, 6'b000000};
						9:       exp_byte = {4'b0000, AC};
						10:      exp_byte = {4'b0011, ~row.lines[3], 2'b10, ~row.lines[1]};
						11:      exp_byte = {1'b0, ~row.lines[0], 6'b000000};
						default: exp_byte = 8'h00;
					endcase
					read_reg(A_OREG0 + 6'(n), data);
					check_byte($sformatf("OREG%0d", n), data, exp_byte);
				end
			end
		end

		$display("Run complete with %0d errors", errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== smpc_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module smpc_top #(
	parameter int CMD_DELAY = 60
) (
	input  wire                          CLK,
	input  wire                          RST_N,
	input  wire                          CE,
	input  wire  [3:0]                   AC,
	input  wire  [smpc_pkg::ADDR_W-1:0]  A,
	input  wire  [smpc_pkg::DATA_W-1:0]  DI,
	input  wire                          CS_N,
	input  wire                          RW_N,
	output wire  [smpc_pkg::DATA_W-1:0]  DO,
	output wire                          MSHRES_N,
	output wire                          MSHNMI_N,
	output wire                          SSHRES_N,
	output wire                          SSHNMI_N,
	output wire                          SNDRES_N,
	output wire                          CDRES_N,
	output wire                          MIRQ_N
);

	logic [smpc_pkg::IREG_N*smpc_pkg::DATA_W-1:0] ireg;
	logic [smpc_pkg::DATA_W-1:0]                  comreg;
	logic                                         cmd_pend;
	logic                                         cmd_take;
	logic                                         sf_set;
	logic                                         rd_stb;
	logic [smpc_pkg::ADDR_W-1:0]                  rd_addr;
	logic                                         oreg_we;
	logic [smpc_pkg::OREG_AW-1:0]                 oreg_wa;
	logic                                         oreg_sel;
	logic                                         resd;
	logic [2:0]                                   sr_hi;
	logic                                         sf;

	smpc_host_decode u_decode (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.A        (A),
		.DI       (DI),
		.CS_N     (CS_N),
		.RW_N     (RW_N),
		.cmd_take (cmd_take),
		.ireg     (ireg),
		.comreg   (comreg),
		.cmd_pend (cmd_pend),
		.sf_set   (sf_set),
		.rd_stb   (rd_stb),
		.rd_addr  (rd_addr)
	);

	smpc_cmd_exec #(
		.CMD_DELAY (CMD_DELAY)
	) u_exec (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.CE       (CE),
		.ireg     (ireg),
		.comreg   (comreg),
		.cmd_pend (cmd_pend),
		.sf_set   (sf_set),
		.cmd_take (cmd_take),
		.oreg_we  (oreg_we),
		.oreg_wa  (oreg_wa),
		.oreg_sel (oreg_sel),
		.resd     (resd),
		.sr_hi    (sr_hi),
		.sf       (sf),
		.MSHRES_N (MSHRES_N),
		.MSHNMI_N (MSHNMI_N),
		.SSHRES_N (SSHRES_N),
		.SSHNMI_N (SSHNMI_N),
		.SNDRES_N (SNDRES_N),
		.CDRES_N  (CDRES_N),
		.MIRQ_N   (MIRQ_N)
	);

	smpc_status_result u_result (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.oreg_we  (oreg_we),
		.oreg_wa  (oreg_wa),
		.oreg_sel (oreg_sel),
		.comreg   (comreg),
		.resd     (resd),
		.sr_hi    (sr_hi),
		.sf       (sf),
		.ireg1_hi (ireg[2*smpc_pkg::DATA_W-1 -: 4]),	// IREG1 upper nibble
		.AC       (AC),
		.MSHNMI_N (MSHNMI_N),
		.SNDRES_N (SNDRES_N),
		.CDRES_N  (CDRES_N),
		.rd_stb   (rd_stb),
		.rd_addr  (rd_addr),
		.DO       (DO)
	);

endmodule

`default_nettype wire

// ==== smpc_status_result.sv ====
`timescale 1ns/10ps
`default_nettype none

module smpc_status_result (
	input  wire                            CLK,
	input  wire                            RST_N,
	input  wire                            oreg_we,
	input  wire  [smpc_pkg::OREG_AW-1:0]   oreg_wa,
	input  wire                            oreg_sel,
	input  wire  [smpc_pkg::DATA_W-1:0]    comreg,
	input  wire                            resd,
	input  wire  [2:0]                     sr_hi,
	input  wire                            sf,
	input  wire  [3:0]                     ireg1_hi,
	input  wire  [3:0]                     AC,
	input  wire                            MSHNMI_N,
	input  wire                            SNDRES_N,
	input  wire                            CDRES_N,
	input  wire                            rd_stb,
	input  wire  [smpc_pkg::ADDR_W-1:0]    rd_addr,
	output logic [smpc_pkg::DATA_W-1:0]    DO
);

	localparam logic [smpc_pkg::OREG_AW-1:0] OREG_A_OFS = 5'h10;	// A of OREG0

	logic [smpc_pkg::DATA_W-1:0]  oreg_ram [2**smpc_pkg::OREG_AW];
	logic [smpc_pkg::DATA_W-1:0]  stat_byte;
	logic [smpc_pkg::ADDR_W:0]    rd_badr;
	logic [smpc_pkg::OREG_AW-1:0] rd_idx;

	// Time and SMEM slots stay zero
	always_comb begin
		case (oreg_wa)
			5'd0:    stat_byte = {1'b0, resd, 6'b000000};
			5'd9:    stat_byte = {4'b0000, AC};
			5'd10:   stat_byte = {2'b00, 2'b11, ~MSHNMI_N, 1'b1, 1'b0, ~SNDRES_N};
			5'd11:   stat_byte = {1'b0, ~CDRES_N, 6'b000000};
			default: stat_byte = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (oreg_we)
			oreg_ram[oreg_wa] <= oreg_sel ? comreg : stat_byte;
	end

	assign rd_badr = {rd_addr, 1'b1};
	assign rd_idx = rd_addr[smpc_pkg::OREG_AW-1:0] - OREG_A_OFS;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			DO <= '0;
		end else if (rd_stb) begin
			if (rd_badr <= smpc_pkg::ADR_OREG_LAST)
				DO <= oreg_ram[rd_idx];
			else if (rd_badr == smpc_pkg::ADR_SR)
				DO <= {sr_hi, 1'b0, ireg1_hi};
			else if (rd_badr == smpc_pkg::ADR_SF)
				DO <= {7'b1111000, sf};	// Upper bits read as set
			else
				DO <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== smpc_cmd_exec.sv ====
`timescale 1ns/10ps
`default_nettype none

module smpc_cmd_exec #(
	parameter int CMD_DELAY = 60
) (
	input  wire                                           CLK,
	input  wire                                           RST_N,
	input  wire                                           CE,
	input  wire  [smpc_pkg::IREG_N*smpc_pkg::DATA_W-1:0]  ireg,
	input  wire  [smpc_pkg::DATA_W-1:0]                   comreg,
	input  wire                                           cmd_pend,
	input  wire                                           sf_set,
	output logic                                          cmd_take,
	output logic                                          oreg_we,
	output logic [smpc_pkg::OREG_AW-1:0]                  oreg_wa,
	output logic                                          oreg_sel,
	output logic                                          resd,
	output logic [2:0]                                    sr_hi,
	output logic                                          sf,
	output logic                                          MSHRES_N,
	output logic                                          MSHNMI_N,
	output logic                                          SSHRES_N,
	output logic                                          SSHNMI_N,
	output logic                                          SNDRES_N,
	output logic                                          CDRES_N,
	output logic                                          MIRQ_N
);

	localparam logic [smpc_pkg::WAIT_W-1:0] DELAY_CNT = CMD_DELAY[smpc_pkg::WAIT_W-1:0];

	smpc_pkg::exec_state_t          st;
	smpc_pkg::exec_state_t          next_st;	// Where WAIT goes
	logic [smpc_pkg::WAIT_W-1:0]    wait_cnt;
	logic [smpc_pkg::WAIT_W-1:0]    cmd_wait;
	logic [smpc_pkg::OREG_AW-1:0]   oreg_cnt;
	logic                           intback_ok;

	assign intback_ok = (ireg[2*smpc_pkg::DATA_W +: smpc_pkg::DATA_W] == smpc_pkg::INTBACK_KEY)
		&& ireg[0];

	always_comb begin
		case (comreg)
			smpc_pkg::CMD_MSHON, smpc_pkg::CMD_SSHON, smpc_pkg::CMD_SSHOFF,
			smpc_pkg::CMD_SNDON, smpc_pkg::CMD_SNDOFF:
				cmd_wait = smpc_pkg::WAIT_POWER;
			smpc_pkg::CMD_CDON, smpc_pkg::CMD_CDOFF:
				cmd_wait = smpc_pkg::WAIT_CD;
			smpc_pkg::CMD_NMIREQ, smpc_pkg::CMD_RESENAB, smpc_pkg::CMD_RESDISA:
				cmd_wait = smpc_pkg::WAIT_NMI;
			default:
				cmd_wait = '0;	// Unknown goes straight to EXEC
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			st <= smpc_pkg::IDLE;
			next_st <= smpc_pkg::IDLE;
			wait_cnt <= '0;
			oreg_cnt <= '0;
			cmd_take <= 1'b0;
			oreg_we <= 1'b0;
			oreg_wa <= '0;
			oreg_sel <= 1'b0;
			resd <= 1'b1;
			sr_hi <= 3'b000;
			sf <= 1'b0;
			MSHRES_N <= 1'b1;
			MSHNMI_N <= 1'b1;
			SSHRES_N <= 1'b0;
			SSHNMI_N <= 1'b1;
			SNDRES_N <= 1'b0;
			CDRES_N <= 1'b1;
			MIRQ_N <= 1'b1;
		end else begin
			cmd_take <= 1'b0;
			oreg_we <= 1'b0;
			if (CE) begin
				case (st)
					smpc_pkg::IDLE: begin
						MIRQ_N <= 1'b1;
						if (cmd_pend) begin
							cmd_take <= 1'b1;
							oreg_cnt <= '0;
							wait_cnt <= DELAY_CNT;
							next_st <= smpc_pkg::COMMAND;
							st <= smpc_pkg::WAIT;
						end
					end

					smpc_pkg::WAIT: begin
						if (wait_cnt == '0)
							st <= next_st;
						else
							wait_cnt <= wait_cnt - 1'b1;
					end

					smpc_pkg::COMMAND: begin
						if (comreg == smpc_pkg::CMD_INTBACK) begin
							if (intback_ok) begin
								oreg_we <= 1'b1;	// One status byte per cycle
								oreg_wa <= oreg_cnt;
								oreg_sel <= 1'b0;
								oreg_cnt <= oreg_cnt + 1'b1;
								if (oreg_cnt == '1) begin
									wait_cnt <= smpc_pkg::WAIT_INTBACK - 1'b1;
									next_st <= smpc_pkg::EXEC;
									st <= smpc_pkg::WAIT;
								end
							end else begin
								st <= smpc_pkg::END;
							end
						end else if (cmd_wait != '0) begin
							wait_cnt <= cmd_wait - 1'b1;
							next_st <= smpc_pkg::EXEC;
							st <= smpc_pkg::WAIT;
						end else begin
							st <= smpc_pkg::EXEC;
						end
					end

					smpc_pkg::EXEC: begin
						oreg_we <= 1'b1;
						oreg_wa <= smpc_pkg::OREG_CMD_IDX;
						oreg_sel <= 1'b1;	// Echo command code
						case (comreg)
							smpc_pkg::CMD_MSHON: begin
								MSHRES_N <= 1'b1;
								MSHNMI_N <= 1'b1;
							end
							smpc_pkg::CMD_SSHON: begin
								SSHRES_N <= 1'b1;
								SSHNMI_N <= 1'b1;
							end
							smpc_pkg::CMD_SSHOFF:
								SSHRES_N <= 1'b0;
							smpc_pkg::CMD_SNDON:
								SNDRES_N <= 1'b1;
							smpc_pkg::CMD_SNDOFF:
								SNDRES_N <= 1'b0;
							smpc_pkg::CMD_CDON:
								CDRES_N <= 1'b1;
							smpc_pkg::CMD_CDOFF:
								CDRES_N <= 1'b0;
							smpc_pkg::CMD_NMIREQ:
								MSHNMI_N <= 1'b0;	// Released in END
							smpc_pkg::CMD_RESENAB:
								resd <= 1'b0;
							smpc_pkg::CMD_RESDISA:
								resd <= 1'b1;
							smpc_pkg::CMD_INTBACK: begin
								sr_hi <= 3'b010;
								MIRQ_N <= 1'b0;
							end
							default: ;
						endcase
						st <= smpc_pkg::END;
					end

					smpc_pkg::END: begin
						sf <= 1'b0;
						if (comreg == smpc_pkg::CMD_NMIREQ)
							MSHNMI_N <= 1'b1;
						st <= smpc_pkg::IDLE;
					end

					default:
						st <= smpc_pkg::IDLE;
				endcase
			end
			if (sf_set)
				sf <= 1'b1;	// Host write beats END
		end
	end

endmodule

`default_nettype wire

// ==== smpc_host_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module smpc_host_decode (
	input  wire                                           CLK,
	input  wire                                           RST_N,
	input  wire  [smpc_pkg::ADDR_W-1:0]                   A,
	input  wire  [smpc_pkg::DATA_W-1:0]                   DI,
	input  wire                                           CS_N,
	input  wire                                           RW_N,
	input  wire                                           cmd_take,
	output logic [smpc_pkg::IREG_N*smpc_pkg::DATA_W-1:0]  ireg,
	output logic [smpc_pkg::DATA_W-1:0]                   comreg,
	output logic                                          cmd_pend,
	output logic                                          sf_set,
	output logic                                          rd_stb,
	output logic [smpc_pkg::ADDR_W-1:0]                   rd_addr
);

	logic                        rw_n_old;
	logic                        cs_n_old;
	logic                        wr_stb;
	logic [smpc_pkg::ADDR_W:0]   wr_adr;	// {A,1}
	logic [smpc_pkg::DATA_W-1:0] wr_data;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_old <= 1'b1;
			cs_n_old <= 1'b1;
			wr_stb <= 1'b0;
			rd_stb <= 1'b0;
		end else begin
			rw_n_old <= RW_N;
			cs_n_old <= CS_N;
			wr_stb <= !RW_N && rw_n_old && !CS_N;	// RW_N fall inside CS_N
			rd_stb <= !CS_N && cs_n_old && RW_N;
		end
	end

	always_ff @(posedge CLK) begin
		wr_adr <= {A, 1'b1};
		wr_data <= DI;
		rd_addr <= A;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ireg <= '0;
			comreg <= '0;
			cmd_pend <= 1'b0;
			sf_set <= 1'b0;
		end else begin
			sf_set <= 1'b0;
			if (cmd_take)
				cmd_pend <= 1'b0;
			if (wr_stb) begin
				for (int i = 0; i < smpc_pkg::IREG_N; i++) begin
					if (int'(wr_adr) == int'(smpc_pkg::ADR_IREG0) + 2 * i)
						ireg[i*smpc_pkg::DATA_W +: smpc_pkg::DATA_W] <= wr_data;
				end
				if (wr_adr == smpc_pkg::ADR_COMREG) begin
					comreg <= wr_data;
					cmd_pend <= 1'b1;	// New write wins over take
				end
				if (wr_adr == smpc_pkg::ADR_SF)
					sf_set <= wr_data[0];
			end
		end
	end

endmodule

`default_nettype wire

// ==== smpc_pkg.sv ====
`default_nettype none

package smpc_pkg;

	localparam int DATA_W  = 8;
	localparam int ADDR_W  = 6;
	localparam int IREG_N  = 7;
	localparam int OREG_AW = 5;
	localparam int WAIT_W  = 16;

	// Byte addresses as {A,1}
	localparam logic [ADDR_W:0] ADR_IREG0     = 7'h01;	// IREGn at +2n
	localparam logic [ADDR_W:0] ADR_COMREG    = 7'h1F;
	localparam logic [ADDR_W:0] ADR_OREG_LAST = 7'h5F;	// OREG0 at 0x21
	localparam logic [ADDR_W:0] ADR_SR        = 7'h61;
	localparam logic [ADDR_W:0] ADR_SF        = 7'h63;

	localparam logic [DATA_W-1:0] CMD_MSHON   = 8'h00;
	localparam logic [DATA_W-1:0] CMD_SSHON   = 8'h02;
	localparam logic [DATA_W-1:0] CMD_SSHOFF  = 8'h03;
	localparam logic [DATA_W-1:0] CMD_SNDON   = 8'h06;
	localparam logic [DATA_W-1:0] CMD_SNDOFF  = 8'h07;
	localparam logic [DATA_W-1:0] CMD_CDON    = 8'h08;
	localparam logic [DATA_W-1:0] CMD_CDOFF   = 8'h09;
	localparam logic [DATA_W-1:0] CMD_INTBACK = 8'h10;
	localparam logic [DATA_W-1:0] CMD_NMIREQ  = 8'h18;
	localparam logic [DATA_W-1:0] CMD_RESENAB = 8'h19;
	localparam logic [DATA_W-1:0] CMD_RESDISA = 8'h1A;

	// CE cycles
	localparam logic [WAIT_W-1:0] WAIT_POWER   = 16'd60;
	localparam logic [WAIT_W-1:0] WAIT_CD      = 16'd100;
	localparam logic [WAIT_W-1:0] WAIT_NMI     = 16'd70;
	localparam logic [WAIT_W-1:0] WAIT_INTBACK = 16'd800;

	localparam logic [OREG_AW-1:0] OREG_CMD_IDX = 5'd31;
	localparam logic [DATA_W-1:0]  INTBACK_KEY  = 8'hF0;	// IREG2 for status

	typedef enum logic [2:0] {
		IDLE,
		WAIT,
		COMMAND,
		EXEC,
		END
	} exec_state_t;

endpackage

`default_nettype wire
